/* common/read_settings.svh */
/*
 * read pipeline settings
 * chunk shape, array placement in DRAM and bus widths
 */
`ifndef READ_SETTINGS_SVH
`define READ_SETTINGS_SVH

// chunk shape
`define RP_CSIZE 4
`define RP_CROWS 4
`define RP_NSLOT 4

// bus widths
`define RP_DBW 16
`define RP_GBW 16
`define RP_OFS_BW 4

// array layout, in DRAM lines
`define RP_PITCH 8
`define RP_BASE 64

`endif

/* common/read_pkg.sv */
/*
 * read pipeline types
 * words, DRAM lines, line addresses and the commands passed between
 * the issue, fill and read blocks
 */
`include "read_settings.svh"

package read_pkg;

	//==============================
	// data
	//==============================
	typedef logic [`RP_DBW-1:0] word_t;

	// one DRAM line, also one output vector
	typedef word_t [`RP_CSIZE-1:0] line_t;

	typedef logic [`RP_GBW-1:0] gaddr_t;

	//==============================
	// buffer indices
	//==============================
	typedef logic [$clog2(`RP_NSLOT)-1:0] slot_t;
	typedef logic [$clog2(`RP_CROWS)-1:0] row_t;

	// row write into the chunk buffer
	typedef struct packed {
		slot_t slot;
		row_t  row;
	} wcmd_t;

	// chunk handed from head to address looper
	typedef struct packed {
		gaddr_t base;
		slot_t  slot;
	} chunk_req_t;

endpackage

/* common/rdyack_if.sv */
/*
 * rdy/ack handshake
 * source holds rdy and data until the cycle where ack is also high
 */
`timescale 1ns/1ps

interface rdyack_if #(
	parameter type T = logic
);

	logic rdy;
	logic ack;
	T     data;

	modport src (output rdy, output data, input ack);
	modport dst (input rdy, input data, output ack);

endinterface

/* chunk_issue/chunk_head.sv */
/*
 * chunk head
 * takes block requests, reserves a buffer slot and computes the DRAM
 * line address of the first chunk row
 */
`timescale 1ns/1ps
`include "read_settings.svh"

module chunk_head
	import read_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_bofs_rdy,
	output logic                  o_bofs_ack,
	input  logic [`RP_OFS_BW-1:0] i_bofs_row,
	input  logic [`RP_OFS_BW-1:0] i_bofs_col,
	input  logic                  i_avail,
	output logic                  o_grant,
	input  slot_t                 i_slot,
	rdyack_if.src                 chunk_if
);

logic       req_rdy;
chunk_req_t req_q;
gaddr_t     base_addr;
logic       req_free;
logic       accept;

//==============================
// request accept
//==============================
// held request empty or leaving this cycle
assign req_free = !req_rdy || chunk_if.ack;
assign accept = i_bofs_rdy && i_avail && req_free;
assign o_bofs_ack = accept;
assign o_grant = accept;

// row-major line address of the chunk origin
assign base_addr = gaddr_t'(`RP_BASE + i_bofs_row * `RP_PITCH + i_bofs_col);

//==============================
// held chunk request
//==============================
always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		req_rdy <= 1'b0;
	end else if (accept) begin
		req_rdy <= 1'b1;
	end else if (req_rdy && chunk_if.ack) begin
		req_rdy <= 1'b0;
	end
end

always_ff @(posedge i_clk) begin
	if (accept) begin
		req_q.base <= base_addr;
		req_q.slot <= i_slot;
	end
end

assign chunk_if.rdy = req_rdy;
assign chunk_if.data = req_q;

endmodule

/* chunk_issue/chunk_addr_looper.sv */
/*
 * chunk address looper
 * walks the rows of a chunk, issuing one DRAM read per row and queueing
 * the matching buffer write command for the collector
 */
`timescale 1ns/1ps
`include "read_settings.svh"

module chunk_addr_looper
	import read_pkg::*;
(
	input  logic   i_clk,
	input  logic   i_rst,
	rdyack_if.dst  chunk_if,
	output logic   o_dramra_rdy,
	input  logic   i_dramra_ack,
	output gaddr_t o_dramra,
	rdyack_if.src  wcmd_if
);

localparam int QBW = $clog2(`RP_CROWS);

logic   busy;
gaddr_t cur_base;
slot_t  cur_slot;
row_t   cur_row;
logic   issue;
logic   pop;

wcmd_t          q_mem [`RP_CROWS];
logic [QBW-1:0] q_wp;
logic [QBW-1:0] q_rp;
logic [QBW:0]   q_cnt;

//==============================
// row walk
//==============================
assign chunk_if.ack = chunk_if.rdy && !busy;

// stall while the command queue is full
assign o_dramra_rdy = busy && (q_cnt != (QBW+1)'(`RP_CROWS));
assign issue = o_dramra_rdy && i_dramra_ack;
assign o_dramra = gaddr_t'(cur_base + cur_row * `RP_PITCH);

always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		busy <= 1'b0;
		cur_row <= '0;
	end else if (chunk_if.ack) begin
		busy <= 1'b1;
		cur_row <= '0;
	end else if (issue) begin
		cur_row <= cur_row + 1'b1;
		if (cur_row == row_t'(`RP_CROWS - 1)) begin
			busy <= 1'b0;
		end
	end
end

always_ff @(posedge i_clk) begin
	if (chunk_if.ack) begin
		cur_base <= chunk_if.data.base;
		cur_slot <= chunk_if.data.slot;
	end
end

//==============================
// command queue
//==============================
assign wcmd_if.rdy = q_cnt != '0;
assign wcmd_if.data = q_mem[q_rp];
assign pop = wcmd_if.rdy && wcmd_if.ack;

always_ff @(posedge i_clk) begin
	if (issue) begin
		q_mem[q_wp] <= '{slot: cur_slot, row: cur_row};
	end
end

always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		q_wp <= '0;
		q_rp <= '0;
		q_cnt <= '0;
	end else begin
		if (issue) begin
			q_wp <= q_wp + 1'b1;
		end
		if (pop) begin
			q_rp <= q_rp + 1'b1;
		end
		case ({issue, pop})
			2'b10: q_cnt <= q_cnt + 1'b1;
			2'b01: q_cnt <= q_cnt - 1'b1;
			default: q_cnt <= q_cnt;
		endcase
	end
end

endmodule

/* src/chunk_allocator.sv */
/*
 * chunk allocator
 * circular free list of buffer slots, handing out ids on grant and
 * taking them back when the reader is done
 */
`timescale 1ns/1ps
`include "read_settings.svh"

module chunk_allocator
	import read_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_rst,
	input  logic  i_grant,
	output slot_t o_slot,
	output logic  o_avail,
	rdyack_if.dst free_if
);

localparam int CBW = $clog2(`RP_NSLOT + 1);

slot_t          free_list [`RP_NSLOT];
slot_t          head;
slot_t          tail;
logic [CBW-1:0] used;
logic           put;

// returned slots are always accepted
assign free_if.ack = 1'b1;
assign put = free_if.rdy && free_if.ack;

assign o_slot = free_list[head];
assign o_avail = used != CBW'(`RP_NSLOT);

always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		// every slot starts free, in id order
		for (int i = 0; i < `RP_NSLOT; i++) begin
			free_list[i] <= slot_t'(i);
		end
		head <= '0;
		tail <= '0;
		used <= '0;
	end else begin
		if (i_grant) begin
			head <= head + 1'b1;
		end
		if (put) begin
			free_list[tail] <= free_if.data;
			tail <= tail + 1'b1;
		end
		case ({i_grant, put})
			2'b10: used <= used + 1'b1;
			2'b01: used <= used - 1'b1;
			default: used <= used;
		endcase
	end
end

endmodule

/* src/sram_write_collector.sv */
/*
 * SRAM write collector
 * pairs returning DRAM lines with queued write commands and writes each
 * line into its buffer slot with the words XOR-swizzled across banks
 */
`timescale 1ns/1ps
`include "read_settings.svh"

module sram_write_collector
	import read_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_rst,
	rdyack_if.dst wcmd_if,
	input  logic  i_dramrd_rdy,
	output logic  o_dramrd_ack,
	input  line_t i_dramrd,
	output logic  o_wen,
	output slot_t o_wslot,
	output row_t  o_wrow,
	output line_t o_wline,
	output logic  o_done,
	output slot_t o_done_slot
);

localparam int BANK_BW = $clog2(`RP_CSIZE);

logic  cmd_vld;
wcmd_t cmd;
logic  xfer;
logic  load;

//==============================
// command hold
//==============================
// DRAM data is only taken against a held command
assign o_dramrd_ack = cmd_vld;
assign xfer = i_dramrd_rdy && cmd_vld;

// next command may enter as the current one retires
assign wcmd_if.ack = wcmd_if.rdy && (!cmd_vld || xfer);
assign load = wcmd_if.rdy && wcmd_if.ack;

always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		cmd_vld <= 1'b0;
	end else if (load) begin
		cmd_vld <= 1'b1;
	end else if (xfer) begin
		cmd_vld <= 1'b0;
	end
end

always_ff @(posedge i_clk) begin
	if (load) begin
		cmd <= wcmd_if.data;
	end
end

//==============================
// swizzle and write
//==============================
// word w lands in bank w xor row
always_comb begin : swizzle
	logic [BANK_BW-1:0] bank;
	o_wline = '0;
	for (int w = 0; w < `RP_CSIZE; w++) begin
		bank = BANK_BW'(w) ^ BANK_BW'(cmd.row);
		o_wline[bank] = i_dramrd[w];
	end
end

assign o_wen = xfer;
assign o_wslot = cmd.slot;
assign o_wrow = cmd.row;

// last row of the chunk completes the slot
assign o_done = xfer && (cmd.row == row_t'(`RP_CROWS - 1));
assign o_done_slot = cmd.slot;

endmodule

/* src/remap_reader.sv */
/*
 * remap reader
 * owns the banked chunk buffer, serves finished chunks one row per
 * transfer in completion order, and returns each slot after its last row
 */
`timescale 1ns/1ps
`include "read_settings.svh"

module remap_reader
	import read_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_rst,
	input  logic  i_wen,
	input  slot_t i_wslot,
	input  row_t  i_wrow,
	input  line_t i_wline,
	input  logic  i_done,
	input  slot_t i_done_slot,
	output logic  o_sramrd_rdy,
	input  logic  i_sramrd_ack,
	output line_t o_sramrd,
	output logic  o_sramrd_last,
	rdyack_if.src free_if
);

localparam int BANK_BW = $clog2(`RP_CSIZE);
localparam int DEPTH = `RP_NSLOT * `RP_CROWS;
localparam int ABW = $clog2(DEPTH);
localparam int QBW = $clog2(`RP_NSLOT);

word_t          bank_mem [`RP_CSIZE][DEPTH];
logic [ABW-1:0] waddr;
logic [ABW-1:0] raddr;
slot_t          dq_mem [`RP_NSLOT];
logic [QBW-1:0] dq_wp;
logic [QBW-1:0] dq_rp;
logic [QBW:0]   dq_cnt;
slot_t          rd_slot;
row_t           rd_row;
logic           rd_xfer;
logic           rd_end;
logic           free_rdy;
slot_t          free_slot;

//==============================
// banked buffer
//==============================
assign waddr = ABW'({i_wslot, i_wrow});

always_ff @(posedge i_clk) begin
	if (i_wen) begin
		for (int b = 0; b < `RP_CSIZE; b++) begin
			bank_mem[b][waddr] <= i_wline[b];
		end
	end
end

// undo the write swizzle, back to word order
always_comb begin : unswizzle
	logic [BANK_BW-1:0] bank;
	for (int w = 0; w < `RP_CSIZE; w++) begin
		bank = BANK_BW'(w) ^ BANK_BW'(rd_row);
		o_sramrd[w] = bank_mem[bank][raddr];
	end
end

//==============================
// done queue and row walk
//==============================
assign rd_slot = dq_mem[dq_rp];
assign raddr = ABW'({rd_slot, rd_row});
assign o_sramrd_rdy = dq_cnt != '0;
assign o_sramrd_last = rd_row == row_t'(`RP_CROWS - 1);
assign rd_xfer = o_sramrd_rdy && i_sramrd_ack;
assign rd_end = rd_xfer && o_sramrd_last;

always_ff @(posedge i_clk) begin
	if (i_done) begin
		dq_mem[dq_wp] <= i_done_slot;
	end
end

always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		dq_wp <= '0;
		dq_rp <= '0;
		dq_cnt <= '0;
		rd_row <= '0;
	end else begin
		if (i_done) begin
			dq_wp <= dq_wp + 1'b1;
		end
		if (rd_xfer) begin
			rd_row <= o_sramrd_last ? '0 : rd_row + 1'b1;
		end
		if (rd_end) begin
			dq_rp <= dq_rp + 1'b1;
		end
		case ({i_done, rd_end})
			2'b10: dq_cnt <= dq_cnt + 1'b1;
			2'b01: dq_cnt <= dq_cnt - 1'b1;
			default: dq_cnt <= dq_cnt;
		endcase
	end
end

//==============================
// slot return
//==============================
always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		free_rdy <= 1'b0;
	end else if (rd_end) begin
		free_rdy <= 1'b1;
	end else if (free_if.ack) begin
		free_rdy <= 1'b0;
	end
end

always_ff @(posedge i_clk) begin
	if (rd_end) begin
		free_slot <= rd_slot;
	end
end

assign free_if.rdy = free_rdy;
assign free_if.data = free_slot;

endmodule

/* src/read_pipeline.sv */
/*
 * read pipeline top
 * block requests in, DRAM reads out and back, chunk rows out as vectors
 */
`timescale 1ns/1ps
`include "read_settings.svh"

module read_pipeline
	import read_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_bofs_rdy,
	output logic                  o_bofs_ack,
	input  logic [`RP_OFS_BW-1:0] i_bofs_row,
	input  logic [`RP_OFS_BW-1:0] i_bofs_col,
	output logic                  o_dramra_rdy,
	input  logic                  i_dramra_ack,
	output gaddr_t                o_dramra,
	input  logic                  i_dramrd_rdy,
	output logic                  o_dramrd_ack,
	input  line_t                 i_dramrd,
	output logic                  o_sramrd_rdy,
	input  logic                  i_sramrd_ack,
	output line_t                 o_sramrd,
	output logic                  o_sramrd_last
);

logic  grant;
logic  avail;
slot_t alloc_slot;
logic  wen;
slot_t wslot;
row_t  wrow;
line_t wline;
logic  done;
slot_t done_slot;

rdyack_if #(.T(chunk_req_t)) chunk_if ();
rdyack_if #(.T(wcmd_t))      wcmd_if ();
rdyack_if #(.T(slot_t))      free_if ();

//==============================
// chunk issue
//==============================
chunk_head u_chunk_head (
	.i_clk      (i_clk),
	.i_rst      (i_rst),
	.i_bofs_rdy (i_bofs_rdy),
	.o_bofs_ack (o_bofs_ack),
	.i_bofs_row (i_bofs_row),
	.i_bofs_col (i_bofs_col),
	.i_avail    (avail),
	.o_grant    (grant),
	.i_slot     (alloc_slot),
	.chunk_if   (chunk_if.src)
);

chunk_addr_looper u_chunk_addr_looper (
	.i_clk        (i_clk),
	.i_rst        (i_rst),
	.chunk_if     (chunk_if.dst),
	.o_dramra_rdy (o_dramra_rdy),
	.i_dramra_ack (i_dramra_ack),
	.o_dramra     (o_dramra),
	.wcmd_if      (wcmd_if.src)
);

//==============================
// buffer fill
//==============================
chunk_allocator u_chunk_allocator (
	.i_clk   (i_clk),
	.i_rst   (i_rst),
	.i_grant (grant),
	.o_slot  (alloc_slot),
	.o_avail (avail),
	.free_if (free_if.dst)
);

sram_write_collector u_sram_write_collector (
	.i_clk        (i_clk),
	.i_rst        (i_rst),
	.wcmd_if      (wcmd_if.dst),
	.i_dramrd_rdy (i_dramrd_rdy),
	.o_dramrd_ack (o_dramrd_ack),
	.i_dramrd     (i_dramrd),
	.o_wen        (wen),
	.o_wslot      (wslot),
	.o_wrow       (wrow),
	.o_wline      (wline),
	.o_done       (done),
	.o_done_slot  (done_slot)
);

//==============================
// buffer read
//==============================
remap_reader u_remap_reader (
	.i_clk         (i_clk),
	.i_rst         (i_rst),
	.i_wen         (wen),
	.i_wslot       (wslot),
	.i_wrow        (wrow),
	.i_wline       (wline),
	.i_done        (done),
	.i_done_slot   (done_slot),
	.o_sramrd_rdy  (o_sramrd_rdy),
	.i_sramrd_ack  (i_sramrd_ack),
	.o_sramrd      (o_sramrd),
	.o_sramrd_last (o_sramrd_last),
	.free_if       (free_if.src)
);

endmodule

/* test/read_pipeline_sva.sv */
/*
 * read pipeline assertions
 * handshake hold on the DRAM address and output ports, idle outputs
 * in reset, DRAM data taken only against a queued command
 */
`timescale 1ns/1ps

module read_pipeline_sva
	import read_pkg::*;
(
	input logic   i_clk,
	input logic   i_rst,
	input logic   o_bofs_ack,
	input logic   o_dramra_rdy,
	input logic   i_dramra_ack,
	input gaddr_t o_dramra,
	input logic   o_dramrd_ack,
	input logic   o_sramrd_rdy,
	input logic   i_sramrd_ack,
	input line_t  o_sramrd,
	input logic   o_sramrd_last,
	input logic   i_wcmd_rdy
);

a_dramra_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
	o_dramra_rdy && !i_dramra_ack |=> o_dramra_rdy && $stable(o_dramra))
	else $error("DRAM address dropped or changed before ack");

a_sramrd_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
	o_sramrd_rdy && !i_sramrd_ack |=>
	o_sramrd_rdy && $stable(o_sramrd) && $stable(o_sramrd_last))
	else $error("output vector dropped or changed before ack");

// all control outputs idle while reset is held
a_reset_idle: assert property (@(posedge i_clk)
	!i_rst |-> !o_bofs_ack && !o_dramra_rdy && !o_dramrd_ack && !o_sramrd_rdy)
	else $error("control output active during reset");

a_dramrd_cmd: assert property (@(posedge i_clk) disable iff (!i_rst)
	$rose(o_dramrd_ack) |-> $past(i_wcmd_rdy))
	else $error("DRAM data ack raised without a queued command");

endmodule

bind read_pipeline read_pipeline_sva u_sva (.*, .i_wcmd_rdy(wcmd_if.rdy));

/* test/read_pipeline_tb.sv */
/*
 * read pipeline testbench
 * random block requests against a DRAM model, with checks on the
 * address stream, output vectors, last flags, back-pressure and reset
 */
`timescale 1ns/1ps
`include "read_settings.svh"

module read_pipeline_tb
	import read_pkg::*;
();

localparam int CLK_PERIOD = 100;
localparam int NREQ = 40;
localparam int NROWS = NREQ * `RP_CROWS;
localparam int HOLD_CYCLES = 40;
localparam longint WATCHDOG_CYCLES = NREQ * `RP_CROWS * 40;

logic                  i_clk;
logic                  i_rst;
logic                  i_bofs_rdy;
logic                  o_bofs_ack;
logic [`RP_OFS_BW-1:0] i_bofs_row;
logic [`RP_OFS_BW-1:0] i_bofs_col;
logic                  o_dramra_rdy;
logic                  i_dramra_ack;
gaddr_t                o_dramra;
logic                  i_dramrd_rdy;
logic                  o_dramrd_ack;
line_t                 i_dramrd;
logic                  o_sramrd_rdy;
logic                  i_sramrd_ack;
line_t                 o_sramrd;
logic                  o_sramrd_last;

// offsets of each request in issue order
logic [`RP_OFS_BW-1:0] req_row [NREQ];
logic [`RP_OFS_BW-1:0] req_col [NREQ];
// acked DRAM addresses waiting for their line
gaddr_t                dram_q [$];
logic                  hold_out;
int                    n_issued = 0;
int                    n_accepted = 0;
int                    n_addr = 0;
int                    n_sent = 0;
int                    n_lines = 0;
int                    n_rows = 0;

read_pipeline UUT (.*);

initial begin
	i_clk = 1'b0;
	forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
end

//==============================
// reference model
//==============================
// word w of the DRAM line at address a
function automatic word_t dram_word(gaddr_t a, int w);
	return word_t'({a[11:0], 4'(w)}) ^ 16'hc35a;
endfunction

function automatic line_t dram_line(gaddr_t a);
	line_t l;
	for (int w = 0; w < `RP_CSIZE; w++) begin
		l[w] = dram_word(a, w);
	end
	return l;
endfunction

function automatic gaddr_t expected_addr(int k, int r);
	return gaddr_t'(`RP_BASE + (int'(req_row[k]) + r) * `RP_PITCH + int'(req_col[k]));
endfunction

// expected vector for row r of request k in word order
function automatic line_t ref_line(int k, int r);
	line_t l;
	for (int w = 0; w < `RP_CSIZE; w++) begin
		l[w] = dram_word(expected_addr(k, r), w);
	end
	return l;
endfunction

//==============================
// checks
//==============================
task automatic fail_run();
	$display("Errors found");
	$fatal(1, "simulation stopped on first failure");
endtask

task automatic check_addr(gaddr_t got, gaddr_t exp);
	if (got !== exp) begin
		$display("Error: o_dramra got 0x%h, expected 0x%h", got, exp);
		fail_run();
	end
endtask

task automatic check_line(line_t got, line_t exp);
	if (got !== exp) begin
		$display("Error: o_sramrd got 0x%h, expected 0x%h", got, exp);
		fail_run();
	end
endtask

task automatic check_last(logic got, logic exp);
	if (got !== exp) begin
		$display("Error: o_sramrd_last got 0x%h, expected 0x%h", got, exp);
		fail_run();
	end
endtask

task automatic check_quiet(string name, logic got);
	if (got !== 1'b0) begin
		$display("Error: %s got 0x%h, expected 0x0 around reset", name, got);
		fail_run();
	end
endtask

task automatic check_idle();
	check_quiet("o_bofs_ack", o_bofs_ack);
	check_quiet("o_dramra_rdy", o_dramra_rdy);
	check_quiet("o_dramrd_ack", o_dramrd_ack);
	check_quiet("o_sramrd_rdy", o_sramrd_rdy);
endtask

// transfers are taken where rdy and ack meet at the rising edge
always @(posedge i_clk) begin : compare
	if (i_rst) begin
		if (i_bofs_rdy && o_bofs_ack) begin
			n_accepted++;
		end
		if (o_dramra_rdy && i_dramra_ack) begin
			check_addr(o_dramra, expected_addr(n_addr / `RP_CROWS, n_addr % `RP_CROWS));
			dram_q.push_back(o_dramra);
			n_addr++;
		end
		if (i_dramrd_rdy && o_dramrd_ack) begin
			n_lines++;
		end
		if (o_sramrd_rdy && i_sramrd_ack) begin
			check_line(o_sramrd, ref_line(n_rows / `RP_CROWS, n_rows % `RP_CROWS));
			check_last(o_sramrd_last, (n_rows % `RP_CROWS) == `RP_CROWS - 1);
			n_rows++;
		end
	end
end

//==============================
// stimulus
//==============================
task automatic drive_cycle();
	// request held until taken
	if (i_bofs_rdy && n_accepted == n_issued) begin
		i_bofs_rdy = 1'b0;
	end
	if (!i_bofs_rdy && n_issued < NREQ && $urandom_range(1) == 0) begin
		req_row[n_issued] = $urandom_range((1 << `RP_OFS_BW) - 1);
		req_col[n_issued] = $urandom_range((1 << `RP_OFS_BW) - 1);
		i_bofs_row = req_row[n_issued];
		i_bofs_col = req_col[n_issued];
		i_bofs_rdy = 1'b1;
		n_issued++;
	end
	// DRAM model returns lines in address order
	if (i_dramrd_rdy && n_lines == n_sent) begin
		i_dramrd_rdy = 1'b0;
	end
	if (!i_dramrd_rdy && dram_q.size() != 0 && $urandom_range(3) != 0) begin
		i_dramrd = dram_line(dram_q.pop_front());
		i_dramrd_rdy = 1'b1;
		n_sent++;
	end
	i_dramra_ack = $urandom_range(3) != 0;
	i_sramrd_ack = !hold_out && ($urandom_range(3) != 0);
endtask

initial begin : main
	int cycle;
	void'($urandom(19));
	i_rst = 1'b0;
	i_bofs_rdy = 1'b0;
	i_bofs_row = '0;
	i_bofs_col = '0;
	i_dramra_ack = 1'b0;
	i_dramrd_rdy = 1'b0;
	i_dramrd = '0;
	i_sramrd_ack = 1'b0;
	hold_out = 1'b1;
	repeat (3) begin
		@(negedge i_clk);
		check_idle();
	end
	i_rst = 1'b1;
	cycle = 0;
	while (n_rows < NROWS) begin
		@(negedge i_clk);
		if (cycle == 0) begin
			check_idle();
		end
		// exactly the free slots are taken while the output is held
		if (cycle == HOLD_CYCLES) begin
			if (n_accepted != `RP_NSLOT) begin
				$display("Back-pressure failed, %0d chunks taken with output held", n_accepted);
				fail_run();
			end
			hold_out = 1'b0;
		end
		drive_cycle();
		cycle++;
	end
	if (n_addr != NROWS || o_sramrd_rdy) begin
		$display("Pipeline not drained, %0d DRAM addresses for %0d rows or output still offered",
			n_addr, NROWS);
		fail_run();
	end else begin
		$display("No errors");
		$finish;
	end
end

initial begin : watchdog
	#(WATCHDOG_CYCLES * CLK_PERIOD);
	$display("Timeout with only %0d of %0d rows delivered", n_rows, NROWS);
	fail_run();
end

endmodule

/* all.f */
+incdir+common
common/read_pkg.sv
common/rdyack_if.sv
chunk_issue/chunk_head.sv
chunk_issue/chunk_addr_looper.sv
src/chunk_allocator.sv
src/sram_write_collector.sv
src/remap_reader.sv
src/read_pipeline.sv
test/read_pipeline_sva.sv
test/read_pipeline_tb.sv

/* Bender.yml */
package:
  name: read_pipeline

export_include_dirs:
  - common

sources:
  - common/read_pkg.sv
  - common/rdyack_if.sv
  - chunk_issue/chunk_head.sv
  - chunk_issue/chunk_addr_looper.sv
  - src/chunk_allocator.sv
  - src/sram_write_collector.sv
  - src/remap_reader.sv
  - src/read_pipeline.sv
  - target: test
    files:
      - test/read_pipeline_sva.sv
      - test/read_pipeline_tb.sv
